//--- hdl/mem_space_pkg.sv
/* Memory space shared definitions */

package mem_space_pkg;

    // ========================================
    // Widths and constants
    // ========================================
    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int SEL_W     = 4;
    localparam int ATAG_W    = 2;
    localparam int PAGE_W    = 12;
    localparam int RAM_WORDS = 256;
    localparam int RAM_IDX_W = 8;
    localparam int CSR_NUM_W = 12;

    // Tag mask that marks a CSR instruction on the data port
    localparam logic [ATAG_W-1:0] ATAG_CSR_INSTR = 2'b01;

    // Region pages, top address bits
    localparam logic [PAGE_W-1:0] RAM_PAGE = 12'h800;
    localparam logic [PAGE_W-1:0] CSR_PAGE = 12'h400;

    // Machine trap CSRs
    localparam logic [CSR_NUM_W-1:0] CSR_MSCRATCH = 12'h340;
    localparam logic [CSR_NUM_W-1:0] CSR_MEPC     = 12'h341;
    localparam logic [CSR_NUM_W-1:0] CSR_MCAUSE   = 12'h342;
    localparam logic [CSR_NUM_W-1:0] CSR_MTVAL    = 12'h343;

    // Inter-stage FIFO sizing
    localparam int FIFO_DEPTH = 2;
    localparam int FIFO_PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CREDIT_W   = $clog2(FIFO_DEPTH + 1);

    // ========================================
    // Types
    // ========================================
    typedef enum logic {
        PORT_CORE = 1'b0,
        PORT_DATA = 1'b1
    } port_e;

    typedef enum logic [1:0] {
        TGT_RAM   = 2'd0,
        TGT_CSR   = 2'd1,
        TGT_FAULT = 2'd2
    } target_e;

    typedef struct packed {
        logic              stb;
        logic              cyc;
        logic              we;
        logic [SEL_W-1:0]  sel;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [ATAG_W-1:0] atag;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic              err;
        logic [DATA_W-1:0] data;
        logic              tag;
    } wb_rsp_t;

    typedef struct packed {
        port_e             src;
        logic              we;
        logic [SEL_W-1:0]  sel;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [ATAG_W-1:0] atag;
    } mem_req_t;

    typedef struct packed {
        port_e                src;
        target_e              target;
        logic                 we;
        logic [SEL_W-1:0]     sel;
        logic [RAM_IDX_W-1:0] ram_idx;
        logic [CSR_NUM_W-1:0] csr_num;
        logic [DATA_W-1:0]    data;
        logic                 full_word;
    } dec_req_t;

    typedef struct packed {
        port_e             src;
        logic              err;
        logic [DATA_W-1:0] data;
        logic              tag;
    } mem_rsp_t;

    // Sender credit update: spend on push, refund on downstream pop
    function automatic logic [CREDIT_W-1:0] credit_next(
        input logic [CREDIT_W-1:0] cnt,
        input logic                spend,
        input logic                refund
    );
        case ({spend, refund})
            2'b10:   return cnt - 1'b1;
            2'b01:   return cnt + 1'b1;
            default: return cnt;
        endcase
    endfunction

endpackage

//--- hdl/stage_fifo.sv
/* Credit-returning stage FIFO */

`timescale 1ns/1ps

module stage_fifo #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     push_i,
    input  payload_t push_data_i,
    input  logic     pop_i,
    output logic     valid_o,
    output payload_t pop_data_o,
    output logic     credit_o
);
    import mem_space_pkg::*;

    payload_t                mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr_q;
    logic [FIFO_PTR_W-1:0] rd_ptr_q;
    logic [CREDIT_W-1:0]   count_q;
    logic                  pop;

    // Head is always visible
    assign valid_o    = (count_q != '0);
    assign pop_data_o = mem[rd_ptr_q];
    assign pop        = pop_i & valid_o;

    // One credit back per pop
    assign credit_o = pop;

    // Tail write
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CREDIT_W'(push_i) - CREDIT_W'(pop);
        end
    end

endmodule

//--- hdl/req_arbiter.sv
/* Request arbiter */

`timescale 1ns/1ps

module req_arbiter (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  mem_space_pkg::wb_req_t  core_req_i,
    input  mem_space_pkg::wb_req_t  data_req_i,
    input  logic                    credit_i,
    input  logic                    core_done_i,
    input  logic                    data_done_i,
    output logic                    push_o,
    output mem_space_pkg::mem_req_t push_data_o
);
    import mem_space_pkg::*;

    wb_req_t             req [2];
    logic [1:0]          done;
    logic [1:0]          start;
    logic [1:0]          grant;
    logic [1:0]          pend_q;
    logic [1:0]          busy_q;
    logic [CREDIT_W-1:0] credit_q;
    logic                has_credit;
    port_e               src;

    // Ports indexed by port_e
    assign req[PORT_CORE]  = core_req_i;
    assign req[PORT_DATA]  = data_req_i;
    assign done[PORT_CORE] = core_done_i;
    assign done[PORT_DATA] = data_done_i;

    // ========================================
    // Grant, data before core
    // ========================================
    assign has_credit       = (credit_q != '0);
    assign grant[PORT_DATA] = pend_q[PORT_DATA] & has_credit;
    assign grant[PORT_CORE] = pend_q[PORT_CORE] & ~pend_q[PORT_DATA] & has_credit;
    assign src              = grant[PORT_DATA] ? PORT_DATA : PORT_CORE;
    assign push_o           = |grant;

    // Request fields are held stable by the master until ack/err
    always_comb begin
        push_data_o.src  = src;
        push_data_o.we   = req[src].we;
        push_data_o.sel  = req[src].sel;
        push_data_o.addr = req[src].addr;
        push_data_o.data = req[src].data;
        push_data_o.atag = req[src].atag;
    end

    // ========================================
    // Per-port request tracking
    // ========================================
    for (genvar p = 0; p < 2; p++) begin : g_port
        // New request, first strobe seen while idle
        assign start[p] = req[p].stb & req[p].cyc & ~pend_q[p] & ~busy_q[p];

        always_ff @(posedge clk_i) begin
            if (rst_i) begin
                pend_q[p] <= 1'b0;
                busy_q[p] <= 1'b0;
            end else begin
                // Pending until issued, retried every cycle
                if (start[p]) begin
                    pend_q[p] <= 1'b1;
                end else if (grant[p]) begin
                    pend_q[p] <= 1'b0;
                end
                // In flight until the router sees strobe fall
                if (grant[p]) begin
                    busy_q[p] <= 1'b1;
                end else if (done[p]) begin
                    busy_q[p] <= 1'b0;
                end
            end
        end
    end

    // Credits for the request FIFO
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            credit_q <= CREDIT_W'(FIFO_DEPTH);
        end else begin
            credit_q <= credit_next(credit_q, push_o, credit_i);
        end
    end

endmodule

//--- hdl/addr_decoder.sv
/* Address decoder */

`timescale 1ns/1ps

module addr_decoder (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    valid_i,
    input  mem_space_pkg::mem_req_t req_i,
    input  logic                    credit_i,
    output logic                    pop_o,
    output logic                    push_o,
    output mem_space_pkg::dec_req_t push_data_o
);
    import mem_space_pkg::*;

    logic [CREDIT_W-1:0] credit_q;
    logic [PAGE_W-1:0]   page;
    logic                csr_allowed;
    dec_req_t            dec;

    // Credit is spent as soon as the push is committed
    assign pop_o = valid_i & (credit_q != '0);

    assign page        = req_i.addr[ADDR_W-1 -: PAGE_W];
    assign csr_allowed = (req_i.src == PORT_CORE) || (|(req_i.atag & ATAG_CSR_INSTR));

    always_comb begin
        dec.src       = req_i.src;
        dec.target    = TGT_FAULT;
        dec.we        = req_i.we;
        dec.sel       = req_i.sel;
        // Word index aliases across the page
        dec.ram_idx   = req_i.addr[RAM_IDX_W+1:2];
        dec.csr_num   = req_i.addr[CSR_NUM_W-1:0];
        dec.data      = req_i.data;
        dec.full_word = 1'b0;
        case (page)
            RAM_PAGE: begin
                dec.target = TGT_RAM;
                // Core side only fetches
                if (req_i.src == PORT_CORE) begin
                    dec.we        = 1'b0;
                    dec.sel       = '1;
                    dec.full_word = 1'b1;
                end
            end
            CSR_PAGE: begin
                // Byte selects ignored
                dec.target    = csr_allowed ? TGT_CSR : TGT_FAULT;
                dec.full_word = 1'b1;
            end
            // Flash, IO and unmapped pages
            default: dec.target = TGT_FAULT;
        endcase
    end

    // Payload register
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            push_data_o <= dec;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            push_o   <= 1'b0;
            credit_q <= CREDIT_W'(FIFO_DEPTH);
        end else begin
            push_o   <= pop_o;
            credit_q <= credit_next(credit_q, pop_o, credit_i);
        end
    end

endmodule

//--- hdl/target_access.sv
/* RAM and CSR targets */

`timescale 1ns/1ps

module target_access (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    valid_i,
    input  mem_space_pkg::dec_req_t req_i,
    input  logic                    credit_i,
    output logic                    pop_o,
    output logic                    push_o,
    output mem_space_pkg::mem_rsp_t push_data_o
);
    import mem_space_pkg::*;

    logic [DATA_W-1:0]   ram [RAM_WORDS];
    logic [DATA_W-1:0]   csr_q [4];
    logic [CREDIT_W-1:0] credit_q;
    logic [DATA_W-1:0]   ram_rdata;
    logic [DATA_W-1:0]   csr_rdata;
    logic [SEL_W-1:0]    byte_en;
    logic [1:0]          csr_idx;
    logic                csr_hit;
    logic                ram_wr;
    logic                csr_wr;
    mem_rsp_t            rsp;

    // One access per cycle, gated by credit
    assign pop_o = valid_i & (credit_q != '0);

    // ========================================
    // RAM
    // ========================================
    assign ram_rdata = ram[req_i.ram_idx];
    assign byte_en   = req_i.full_word ? '1 : req_i.sel;
    assign ram_wr    = pop_o & (req_i.target == TGT_RAM) & req_i.we;

    always_ff @(posedge clk_i) begin
        if (ram_wr) begin
            for (int b = 0; b < SEL_W; b++) begin
                if (byte_en[b]) begin
                    ram[req_i.ram_idx][8*b +: 8] <= req_i.data[8*b +: 8];
                end
            end
        end
    end

    // ========================================
    // CSR bank
    // ========================================
    always_comb begin
        csr_hit = 1'b1;
        case (req_i.csr_num)
            CSR_MSCRATCH: csr_idx = 2'd0;
            CSR_MEPC:     csr_idx = 2'd1;
            CSR_MCAUSE:   csr_idx = 2'd2;
            CSR_MTVAL:    csr_idx = 2'd3;
            default: begin
                csr_idx = 2'd0;
                csr_hit = 1'b0;
            end
        endcase
    end

    assign csr_rdata = csr_q[csr_idx];
    assign csr_wr    = pop_o & (req_i.target == TGT_CSR) & req_i.we & csr_hit;

    // Trap registers come up cleared
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < 4; i++) begin
                csr_q[i] <= '0;
            end
        end else if (csr_wr) begin
            csr_q[csr_idx] <= req_i.data;
        end
    end

    // ========================================
    // Response
    // ========================================
    always_comb begin
        rsp.src  = req_i.src;
        rsp.err  = (req_i.target == TGT_FAULT) || ((req_i.target == TGT_CSR) && !csr_hit);
        rsp.data = '0;
        rsp.tag  = 1'b0;
        if (req_i.target == TGT_RAM) begin
            rsp.data = ram_rdata;
            // Compressed instruction flag, core fetch only
            rsp.tag  = (req_i.src == PORT_CORE) && (ram_rdata[1:0] != 2'b11);
        end else if ((req_i.target == TGT_CSR) && csr_hit) begin
            rsp.data = csr_rdata;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            push_data_o <= rsp;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            push_o   <= 1'b0;
            credit_q <= CREDIT_W'(FIFO_DEPTH);
        end else begin
            push_o   <= pop_o;
            credit_q <= credit_next(credit_q, pop_o, credit_i);
        end
    end

endmodule

//--- hdl/resp_router.sv
/* Response router */

`timescale 1ns/1ps

module resp_router (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    valid_i,
    input  mem_space_pkg::mem_rsp_t rsp_i,
    input  logic                    core_stb_i,
    input  logic                    data_stb_i,
    output logic                    pop_o,
    output mem_space_pkg::wb_rsp_t  core_rsp_o,
    output mem_space_pkg::wb_rsp_t  data_rsp_o,
    output logic                    core_done_o,
    output logic                    data_done_o
);
    import mem_space_pkg::*;

    wb_rsp_t    hold_q [2];
    logic [1:0] stb;
    logic [1:0] held;
    logic [1:0] done;

    assign stb[PORT_CORE] = core_stb_i;
    assign stb[PORT_DATA] = data_stb_i;

    // Next response waits while its port still shows ack/err
    assign pop_o = valid_i & ~held[rsp_i.src];

    for (genvar p = 0; p < 2; p++) begin : g_port
        assign held[p] = hold_q[p].ack | hold_q[p].err;
        // Master dropped strobe, transaction over
        assign done[p] = held[p] & ~stb[p];

        always_ff @(posedge clk_i) begin
            if (rst_i) begin
                hold_q[p].ack <= 1'b0;
                hold_q[p].err <= 1'b0;
            end else if (pop_o && (rsp_i.src == port_e'(p))) begin
                hold_q[p].ack <= ~rsp_i.err;
                hold_q[p].err <= rsp_i.err;
            end else if (done[p]) begin
                hold_q[p].ack <= 1'b0;
                hold_q[p].err <= 1'b0;
            end
        end

        // Read data and tag
        always_ff @(posedge clk_i) begin
            if (pop_o && (rsp_i.src == port_e'(p))) begin
                hold_q[p].data <= rsp_i.data;
                hold_q[p].tag  <= rsp_i.tag;
            end
        end
    end

    // Ack/err masked by strobe
    always_comb begin
        core_rsp_o     = hold_q[PORT_CORE];
        core_rsp_o.ack = hold_q[PORT_CORE].ack & core_stb_i;
        core_rsp_o.err = hold_q[PORT_CORE].err & core_stb_i;
        data_rsp_o     = hold_q[PORT_DATA];
        data_rsp_o.ack = hold_q[PORT_DATA].ack & data_stb_i;
        data_rsp_o.err = hold_q[PORT_DATA].err & data_stb_i;
    end

    assign core_done_o = done[PORT_CORE];
    assign data_done_o = done[PORT_DATA];

endmodule

//--- hdl/mem_space.sv
/* Memory space controller */

`timescale 1ns/1ps

module mem_space (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  mem_space_pkg::wb_req_t core_req_i,
    input  mem_space_pkg::wb_req_t data_req_i,
    output mem_space_pkg::wb_rsp_t core_rsp_o,
    output mem_space_pkg::wb_rsp_t data_rsp_o
);
    import mem_space_pkg::*;

    // Arbiter to decoder
    logic     req_push, req_valid, req_pop, req_credit;
    mem_req_t req_push_data, req_head;
    // Decoder to targets
    logic     dec_push, dec_valid, dec_pop, dec_credit;
    dec_req_t dec_push_data, dec_head;
    // Targets to router
    logic     rsp_push, rsp_valid, rsp_pop, rsp_credit;
    mem_rsp_t rsp_push_data, rsp_head;
    // Port release
    logic     core_done, data_done;

    // ========================================
    // Stage chain
    // ========================================
    req_arbiter u_req_arbiter (
        .clk_i, .rst_i, .core_req_i, .data_req_i,
        .credit_i    (req_credit),
        .core_done_i (core_done),
        .data_done_i (data_done),
        .push_o      (req_push),
        .push_data_o (req_push_data)
    );

    stage_fifo #(.payload_t(mem_req_t)) u_req_fifo (
        .clk_i, .rst_i,
        .push_i (req_push), .push_data_i (req_push_data), .pop_i (req_pop),
        .valid_o (req_valid), .pop_data_o (req_head), .credit_o (req_credit)
    );

    addr_decoder u_addr_decoder (
        .clk_i, .rst_i,
        .valid_i (req_valid), .req_i (req_head), .credit_i (dec_credit),
        .pop_o (req_pop), .push_o (dec_push), .push_data_o (dec_push_data)
    );

    stage_fifo #(.payload_t(dec_req_t)) u_dec_fifo (
        .clk_i, .rst_i,
        .push_i (dec_push), .push_data_i (dec_push_data), .pop_i (dec_pop),
        .valid_o (dec_valid), .pop_data_o (dec_head), .credit_o (dec_credit)
    );

    target_access u_target_access (
        .clk_i, .rst_i,
        .valid_i (dec_valid), .req_i (dec_head), .credit_i (rsp_credit),
        .pop_o (dec_pop), .push_o (rsp_push), .push_data_o (rsp_push_data)
    );

    stage_fifo #(.payload_t(mem_rsp_t)) u_rsp_fifo (
        .clk_i, .rst_i,
        .push_i (rsp_push), .push_data_i (rsp_push_data), .pop_i (rsp_pop),
        .valid_o (rsp_valid), .pop_data_o (rsp_head), .credit_o (rsp_credit)
    );

    resp_router u_resp_router (
        .clk_i, .rst_i,
        .valid_i (rsp_valid), .rsp_i (rsp_head),
        .core_stb_i (core_req_i.stb), .data_stb_i (data_req_i.stb),
        .pop_o (rsp_pop), .core_rsp_o, .data_rsp_o,
        .core_done_o (core_done), .data_done_o (data_done)
    );

endmodule

//--- test/mem_space_assert.sv
/* Port protocol assertions */

`timescale 1ns/1ps

module mem_space_assert (
    input logic                                 clk_i,
    input logic                                 rst_i,
    input mem_space_pkg::wb_req_t               core_req_i,
    input mem_space_pkg::wb_req_t               data_req_i,
    input mem_space_pkg::wb_rsp_t               core_rsp_i,
    input mem_space_pkg::wb_rsp_t               data_rsp_i,
    input logic [mem_space_pkg::CREDIT_W-1:0]   req_credit_i,
    input logic [mem_space_pkg::CREDIT_W-1:0]   dec_credit_i,
    input logic [mem_space_pkg::CREDIT_W-1:0]   rsp_credit_i
);
    import mem_space_pkg::*;

    // Failed assertion count
    int unsigned fail_count = 0;

    // Ack and err are exclusive on each port
    a_ack_err_excl: assert property (@(posedge clk_i) disable iff (rst_i)
        !(core_rsp_i.ack && core_rsp_i.err) && !(data_rsp_i.ack && data_rsp_i.err))
        else begin
            $error("ack and err high together on one port");
            fail_count++;
        end

    // Ack/err only while the master strobes
    a_rsp_masked: assert property (@(posedge clk_i) disable iff (rst_i)
        (!(core_rsp_i.ack || core_rsp_i.err) || core_req_i.stb) &&
        (!(data_rsp_i.ack || data_rsp_i.err) || data_req_i.stb))
        else begin
            $error("ack or err seen with strobe low");
            fail_count++;
        end

    // Senders never hold more credits than FIFO slots
    a_credit_bound: assert property (@(posedge clk_i) disable iff (rst_i)
        (req_credit_i <= CREDIT_W'(FIFO_DEPTH)) &&
        (dec_credit_i <= CREDIT_W'(FIFO_DEPTH)) &&
        (rsp_credit_i <= CREDIT_W'(FIFO_DEPTH)))
        else begin
            $error("credit counter above FIFO depth");
            fail_count++;
        end

endmodule

//--- test/tb_mem_space.sv
/* Memory space testbench */

`timescale 1ns/1ps

module tb_mem_space;
    import mem_space_pkg::*;

    // Cycles a port may wait for ack or err
    localparam int TIMEOUT = 200;

    logic    clk_i = 1'b0;
    logic    rst_i;
    wb_req_t core_req;
    wb_req_t data_req;
    wb_rsp_t core_rsp;
    wb_rsp_t data_rsp;

    logic [15:0]       lfsr;
    logic [DATA_W-1:0] ram_model [RAM_WORDS];
    logic [DATA_W-1:0] csr_model [4];
    int                n_checks;
    int                n_fail;

    mem_space u_mem_space (
        .clk_i,
        .rst_i,
        .core_req_i (core_req),
        .data_req_i (data_req),
        .core_rsp_o (core_rsp),
        .data_rsp_o (data_rsp)
    );

    bind mem_space mem_space_assert u_mem_space_assert (
        .clk_i,
        .rst_i,
        .core_req_i,
        .data_req_i,
        .core_rsp_i   (core_rsp_o),
        .data_rsp_i   (data_rsp_o),
        .req_credit_i (u_req_arbiter.credit_q),
        .dec_credit_i (u_addr_decoder.credit_q),
        .rsp_credit_i (u_target_access.credit_q)
    );

    always #20 clk_i = ~clk_i;

    // ========================================
    // Stimulus helpers
    // ========================================
    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Random request biased toward RAM and CSR pages
    function automatic wb_req_t gen_req();
        wb_req_t     r;
        logic [2:0]  kind;
        logic [11:0] page;
        logic [19:0] low;
        kind = 3'(rand_bits(3));
        low  = 20'(rand_bits(20));
        case (kind)
            3'd0, 3'd1, 3'd2: page = RAM_PAGE;
            3'd3, 3'd4: begin
                page = CSR_PAGE;
                // Mostly the four trap CSRs
                if (rand_bits(2) != 0) begin
                    low[11:0] = CSR_MSCRATCH + 12'(rand_bits(2));
                end
            end
            3'd5:    page = 12'h000;   // flash
            3'd6:    page = 12'hF00;   // IO
            default: page = 12'(rand_bits(12));
        endcase
        r.stb  = 1'b1;
        r.cyc  = 1'b1;
        r.we   = 1'(rand_bits(1));
        r.sel  = 4'(rand_bits(4));
        r.addr = {page, low};
        r.data = rand_bits(32);
        r.atag = 2'(rand_bits(2));
        return r;
    endfunction

    // ========================================
    // Reference model
    // ========================================
    // Applied in issue order to give the expected response
    function automatic wb_rsp_t model_access(input port_e src, input wb_req_t r);
        wb_rsp_t              exp;
        logic [11:0]          page;
        logic [RAM_IDX_W-1:0] idx;
        logic [11:0]          num;
        logic                 csr_ok;
        exp    = '0;
        page   = r.addr[31:20];
        idx    = r.addr[9:2];
        num    = r.addr[11:0];
        csr_ok = (src == PORT_CORE) || ((r.atag & ATAG_CSR_INSTR) != '0);
        if (page == RAM_PAGE) begin
            exp.ack  = 1'b1;
            exp.data = ram_model[idx];
            if (src == PORT_CORE) begin
                // Compressed unless both low bits set
                exp.tag = (ram_model[idx][1:0] != 2'b11);
            end else if (r.we) begin
                for (int b = 0; b < SEL_W; b++) begin
                    if (r.sel[b]) begin
                        ram_model[idx][8*b +: 8] = r.data[8*b +: 8];
                    end
                end
            end
        end else if (page == CSR_PAGE && csr_ok && num >= CSR_MSCRATCH && num <= CSR_MTVAL) begin
            exp.ack  = 1'b1;
            exp.data = csr_model[num[1:0]];
            if (r.we) begin
                csr_model[num[1:0]] = r.data;
            end
        end else begin
            exp.err = 1'b1;
        end
        return exp;
    endfunction

    // ========================================
    // Checks and run control
    // ========================================
    task automatic check_rsp(input string name, input wb_rsp_t exp, input wb_rsp_t act);
        n_checks++;
        if (act.ack !== exp.ack || act.err !== exp.err || act.tag !== exp.tag) begin
            n_fail++;
            $display("[FAIL] %s: expected ack=%b err=%b tag=%b, actual ack=%b err=%b tag=%b",
                     name, exp.ack, exp.err, exp.tag, act.ack, act.err, act.tag);
        end
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        n_checks++;
        if (act !== exp) begin
            n_fail++;
            $display("[FAIL] %s: expected data=%h, actual data=%h", name, exp, act);
        end
    endtask

    task automatic close_run(input int timeouts);
        int total;
        total = n_fail + timeouts + u_mem_space.u_mem_space_assert.fail_count;
        $display("checks=%0d failures=%0d assertion_failures=%0d timeouts=%0d",
                 n_checks, n_fail, u_mem_space.u_mem_space_assert.fail_count, timeouts);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic abort_run(input string what);
        $display("Timeout: %s", what);
        close_run(1);
    endtask

    task automatic drive(input port_e p, input wb_req_t r);
        if (p == PORT_DATA) begin
            data_req = r;
        end else begin
            core_req = r;
        end
    endtask

    // One master transaction with strobe held for hold cycles after ack
    task automatic run_txn(input port_e p, input wb_req_t r, input wb_rsp_t exp,
                           input int hold, input string name);
        wb_rsp_t act;
        logic    got;
        logic    rd;
        rd  = exp.ack && (!r.we || (p == PORT_CORE && r.addr[31:20] == RAM_PAGE));
        got = 1'b0;
        act = '0;
        @(posedge clk_i);
        #1;
        drive(p, r);
        for (int i = 0; i < TIMEOUT && !got; i++) begin
            @(negedge clk_i);
            act = (p == PORT_DATA) ? data_rsp : core_rsp;
            got = act.ack | act.err;
        end
        if (!got) begin
            abort_run($sformatf("%s got no ack or err within %0d cycles", name, TIMEOUT));
        end else begin
            check_rsp(name, exp, act);
            if (rd) begin
                check_data(name, exp.data, act.data);
            end
            repeat (hold) @(posedge clk_i);
            @(posedge clk_i);
            #1;
            drive(p, '0);
            // Let the port release before the next start
            @(posedge clk_i);
        end
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        wb_req_t r;
        wb_req_t rc;
        wb_rsp_t exp_d;
        wb_rsp_t exp_c;
        int      hold_d;
        int      hold_c;
        rst_i    = 1'b1;
        core_req = '0;
        data_req = '0;
        lfsr     = 16'd74;
        n_checks = 0;
        n_fail   = 0;
        repeat (2) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        // Known contents for every RAM word and CSR
        for (int i = 0; i < RAM_WORDS; i++) begin
            r      = '0;
            r.stb  = 1'b1;
            r.cyc  = 1'b1;
            r.we   = 1'b1;
            r.sel  = '1;
            r.addr = {RAM_PAGE, 20'(i * 4)};
            r.data = rand_bits(32);
            run_txn(PORT_DATA, r, model_access(PORT_DATA, r), 0, "ram_fill");
        end
        for (int i = 0; i < 4; i++) begin
            r.addr = {CSR_PAGE, 8'h00, 12'(CSR_MSCRATCH + i)};
            r.data = rand_bits(32);
            run_txn(PORT_CORE, r, model_access(PORT_CORE, r), 0, "csr_init");
        end

        // Byte write through an aliased address and read back at the base
        r.addr = {RAM_PAGE, 20'h0F014};
        r.sel  = 4'b0101;
        r.data = rand_bits(32);
        run_txn(PORT_DATA, r, model_access(PORT_DATA, r), 0, "ram_alias_wr");
        r.we   = 1'b0;
        r.addr = {RAM_PAGE, 20'h00014};
        run_txn(PORT_DATA, r, model_access(PORT_DATA, r), 0, "ram_alias_rd");

        // One port at a time
        for (int i = 0; i < 150; i++) begin
            r = gen_req();
            run_txn(PORT_DATA, r, model_access(PORT_DATA, r), rand_bits(2), "data_random");
        end
        for (int i = 0; i < 120; i++) begin
            r = gen_req();
            run_txn(PORT_CORE, r, model_access(PORT_CORE, r), rand_bits(2), "core_random");
        end

        // Same-cycle starts with data issued first
        for (int i = 0; i < 120; i++) begin
            r      = gen_req();
            rc     = gen_req();
            exp_d  = model_access(PORT_DATA, r);
            exp_c  = model_access(PORT_CORE, rc);
            hold_d = (rand_bits(2) == 3) ? 20 : rand_bits(2);
            hold_c = (rand_bits(2) == 3) ? 20 : rand_bits(2);
            fork
                run_txn(PORT_DATA, r, exp_d, hold_d, "concurrent_data");
                run_txn(PORT_CORE, rc, exp_c, hold_c, "concurrent_core");
            join
        end

        close_run(0);
    end

endmodule

//--- mem_space.f
hdl/mem_space_pkg.sv
hdl/stage_fifo.sv
hdl/req_arbiter.sv
hdl/addr_decoder.sv
hdl/target_access.sv
hdl/resp_router.sv
hdl/mem_space.sv
test/mem_space_assert.sv
test/tb_mem_space.sv
